// File: color_track_pkg.sv
package color_track_pkg;

  // pixel coordinates as produced by the camera front end
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // one 8-bit color, luma or chroma sample
  typedef logic [7:0]  color_t;

  // raw 5:6:5 camera word
  typedef logic [15:0] rgb565_t;

  // masked pixel tally and coordinate sums over one frame
  typedef logic [20:0] pix_count_t;
  typedef logic [31:0] coord_sum_t;

  // channel codes, 3 and 7 have no channel and select zero
  typedef enum logic [2:0] {
    ch_green       = 3'd0,
    ch_red         = 3'd1,
    ch_blue        = 3'd2,
    ch_luma        = 3'd4,
    ch_chroma_red  = 3'd5,
    ch_chroma_blue = 3'd6
  } channel_e;

  // background choice for the video mux, all driven by target 0
  typedef enum logic [1:0] {
    camera         = 2'd0,
    channel_gray   = 2'd1,
    mask_white     = 2'd2,
    chroma_magenta = 2'd3
  } display_e;

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_t;

  typedef struct packed {
    color_t y;
    color_t cr;
    color_t cb;
  } ycrcb_t;

  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    rgb565_t rgb;
  } pixel_in_t;

  // per target channel choice and inclusive bounds
  typedef struct packed {
    channel_e channel;
    color_t   lower;
    color_t   upper;
  } target_cfg_t;

  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } com_t;

  // pipeline depths counted from the pixel input
  localparam int COLOR_LATENCY = 3;
  localparam int MASK_LATENCY  = 4;
  localparam int OUT_LATENCY   = 5;

  localparam int NUM_TARGETS = 2;

  localparam rgb_t CROSSHAIR_COLOR = '1;
  localparam rgb_t MAGENTA = '{red: 8'hff, green: 8'h00, blue: 8'hff};

endpackage

// File: pixel_delay.sv
`timescale 1ns/10ps

module pixel_delay #(
  parameter int WIDTH  = 8,
  parameter int STAGES = 1
) (
  input  logic             clk_camera,
  input  logic             sys_rst_pixel,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  // stage 0 takes the input, last stage drives the output
  logic [WIDTH-1:0] pipe_q [STAGES];

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      for (int i = 0; i < STAGES; i++) begin
        pipe_q[i] <= '0;
      end
    end else begin
      pipe_q[0] <= data_i;
      for (int i = 1; i < STAGES; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign data_o = pipe_q[STAGES-1];

endmodule

// File: rgb_to_ycrcb.sv
`timescale 1ns/10ps

module rgb_to_ycrcb (
  input  logic                     clk_camera,
  input  logic                     sys_rst_pixel,
  input  color_track_pkg::rgb565_t pixel_i,
  output color_track_pkg::rgb_t    rgb_o,
  output color_track_pkg::ycrcb_t  ycrcb_o
);

  // stage 1 expanded color, carried along to leave with the result
  color_track_pkg::rgb_t rgb_s1;
  color_track_pkg::rgb_t rgb_s2;

  // stage 2 products, order is y (r g b), cr (r g b), cb (r g b)
  logic signed [17:0] prod [9];

  // stage 3 sums before the shift
  logic signed [19:0] y_sum;
  logic signed [19:0] cr_sum;
  logic signed [19:0] cb_sum;

  // unsigned color times a signed coefficient
  function automatic logic signed [17:0] mul(color_track_pkg::color_t c,
                                             logic signed [8:0] k);
    return $signed({1'b0, c}) * k;
  endfunction

  always_comb begin
    y_sum  = prod[0] + prod[1] + prod[2];
    cr_sum = prod[3] + prod[4] + prod[5];
    cb_sum = prod[6] + prod[7] + prod[8];
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      rgb_s1  <= '0;
      rgb_s2  <= '0;
      rgb_o   <= '0;
      ycrcb_o <= '0;
      for (int i = 0; i < 9; i++) begin
        prod[i] <= '0;
      end
    end else begin
      // 5:6:5 to 8:8:8, low bits zero filled
      rgb_s1.red   <= {pixel_i[15:11], 3'b000};
      rgb_s1.green <= {pixel_i[10:5], 2'b00};
      rgb_s1.blue  <= {pixel_i[4:0], 3'b000};

      // luma weights
      prod[0] <= mul(rgb_s1.red, 9'sd77);
      prod[1] <= mul(rgb_s1.green, 9'sd150);
      prod[2] <= mul(rgb_s1.blue, 9'sd29);
      // chroma red weights
      prod[3] <= mul(rgb_s1.red, 9'sd128);
      prod[4] <= mul(rgb_s1.green, -9'sd107);
      prod[5] <= mul(rgb_s1.blue, -9'sd21);
      // chroma blue weights
      prod[6] <= mul(rgb_s1.red, -9'sd43);
      prod[7] <= mul(rgb_s1.green, -9'sd85);
      prod[8] <= mul(rgb_s1.blue, 9'sd128);
      rgb_s2  <= rgb_s1;

      // divide by 256, chroma gets the 128 offset so it sits in 0..255
      ycrcb_o.y  <= color_track_pkg::color_t'(y_sum >>> 8);
      ycrcb_o.cr <= color_track_pkg::color_t'((cr_sum >>> 8) + 20'sd128);
      ycrcb_o.cb <= color_track_pkg::color_t'((cb_sum >>> 8) + 20'sd128);
      rgb_o      <= rgb_s2;
    end
  end

endmodule

// File: channel_mask.sv
`timescale 1ns/10ps

module channel_mask (
  input  logic                        clk_camera,
  input  logic                        sys_rst_pixel,
  input  color_track_pkg::rgb_t       rgb_i,
  input  color_track_pkg::ycrcb_t     ycrcb_i,
  input  color_track_pkg::target_cfg_t cfg_i,
  output color_track_pkg::color_t     channel_o,
  output logic                        mask_o
);

  color_track_pkg::color_t sel;
  logic                    in_range;

  // pick one of the six channels, unused codes give zero
  always_comb begin
    case (cfg_i.channel)
      color_track_pkg::ch_green:       sel = rgb_i.green;
      color_track_pkg::ch_red:         sel = rgb_i.red;
      color_track_pkg::ch_blue:        sel = rgb_i.blue;
      color_track_pkg::ch_luma:        sel = ycrcb_i.y;
      color_track_pkg::ch_chroma_red:  sel = ycrcb_i.cr;
      color_track_pkg::ch_chroma_blue: sel = ycrcb_i.cb;
      default:                         sel = '0;
    endcase
  end

  // both bounds inclusive
  assign in_range = (sel >= cfg_i.lower) && (sel <= cfg_i.upper);

  // channel and mask leave together so the mux sees them aligned
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      channel_o <= '0;
      mask_o    <= 1'b0;
    end else begin
      channel_o <= sel;
      mask_o    <= in_range;
    end
  end

endmodule

// File: seq_divider.sv
`timescale 1ns/10ps

module seq_divider (
  input  logic                       clk_camera,
  input  logic                       sys_rst_pixel,
  input  logic                       start_i,
  input  color_track_pkg::coord_sum_t dividend_i,
  input  color_track_pkg::pix_count_t divisor_i,
  output logic                       busy_o,
  output logic                       done_o,
  output color_track_pkg::coord_sum_t quotient_o
);

  // dividend bits shift out the top while quotient bits shift in below
  color_track_pkg::coord_sum_t quot_q;
  color_track_pkg::pix_count_t rem_q;
  color_track_pkg::pix_count_t div_q;
  logic [4:0]                  bit_cnt;

  // partial remainder with the next dividend bit appended
  logic [21:0] trial;
  logic [21:0] diff;
  logic        fits;

  assign trial = {rem_q, quot_q[31]};
  assign diff  = trial - {1'b0, div_q};
  assign fits  = trial >= {1'b0, div_q};

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_o) begin
        busy_o  <= 1'b1;
        bit_cnt <= '0;
      end else if (busy_o) begin
        bit_cnt <= bit_cnt + 5'd1;
        // 32nd bit written on this edge
        if (bit_cnt == 5'd31) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (start_i && !busy_o) begin
      quot_q <= dividend_i;
      rem_q  <= '0;
      div_q  <= divisor_i;
    end else if (busy_o) begin
      // remainder stays below the divisor so 21 bits hold it
      rem_q  <= fits ? diff[20:0] : trial[20:0];
      quot_q <= {quot_q[30:0], fits};
    end
  end

  assign quotient_o = quot_q;

endmodule

// File: center_of_mass.sv
`timescale 1ns/10ps

module center_of_mass (
  input  logic                    clk_camera,
  input  logic                    sys_rst_pixel,
  input  logic                    valid_i,
  input  logic                    mask_i,
  input  color_track_pkg::hcount_t hcount_i,
  input  color_track_pkg::vcount_t vcount_i,
  input  logic                    frame_end_i,
  output color_track_pkg::com_t   com_o,
  output logic                    com_valid_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_dividing,
    st_publishing
  } state_e;

  state_e state_q;

  // running totals for the current frame
  color_track_pkg::coord_sum_t x_sum_q;
  color_track_pkg::coord_sum_t y_sum_q;
  color_track_pkg::pix_count_t count_q;

  logic hit;
  logic start;
  logic x_busy, y_busy;
  logic x_done, y_done;
  logic x_got, y_got;
  color_track_pkg::coord_sum_t x_quot, y_quot;

  assign hit = valid_i && mask_i;

  // an empty frame or a frame end during a divide starts nothing
  assign start = frame_end_i && (count_q != '0) && (state_q == st_idle)
                 && !x_busy && !y_busy;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      x_sum_q <= '0;
      y_sum_q <= '0;
      count_q <= '0;
    end else if (frame_end_i) begin
      // sums restart, a pixel on the same edge opens the next frame
      x_sum_q <= hit ? color_track_pkg::coord_sum_t'(hcount_i) : '0;
      y_sum_q <= hit ? color_track_pkg::coord_sum_t'(vcount_i) : '0;
      count_q <= hit ? color_track_pkg::pix_count_t'(1) : '0;
    end else if (hit) begin
      x_sum_q <= x_sum_q + color_track_pkg::coord_sum_t'(hcount_i);
      y_sum_q <= y_sum_q + color_track_pkg::coord_sum_t'(vcount_i);
      count_q <= count_q + 1'b1;
    end
  end

  // dividers latch their operands on start, before the sums clear
  seq_divider u_div_x (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start),
    .dividend_i    (x_sum_q),
    .divisor_i     (count_q),
    .busy_o        (x_busy),
    .done_o        (x_done),
    .quotient_o    (x_quot)
  );

  seq_divider u_div_y (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start),
    .dividend_i    (y_sum_q),
    .divisor_i     (count_q),
    .busy_o        (y_busy),
    .done_o        (y_done),
    .quotient_o    (y_quot)
  );

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      state_q <= st_idle;
      x_got   <= 1'b0;
      y_got   <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          x_got <= 1'b0;
          y_got <= 1'b0;
          if (start) begin
            state_q <= st_dividing;
          end
        end
        st_dividing: begin
          // remember whichever done pulse arrives first
          if (x_done) begin
            x_got <= 1'b1;
          end
          if (y_done) begin
            y_got <= 1'b1;
          end
          if ((x_done || x_got) && (y_done || y_got)) begin
            state_q <= st_publishing;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // mean fits the coordinate width, upper quotient bits are zero
  always_ff @(posedge clk_camera) begin
    if (state_q == st_dividing) begin
      com_o.x <= color_track_pkg::hcount_t'(x_quot);
      com_o.y <= color_track_pkg::vcount_t'(y_quot);
    end
  end

  // one cycle pulse while publishing
  assign com_valid_o = (state_q == st_publishing);

endmodule

// File: overlay_mux.sv
`timescale 1ns/10ps

module overlay_mux (
  input  logic                     clk_camera,
  input  logic                     sys_rst_pixel,
  input  logic                     valid_i,
  input  color_track_pkg::hcount_t hcount_i,
  input  color_track_pkg::vcount_t vcount_i,
  input  color_track_pkg::rgb_t    rgb_i,
  input  color_track_pkg::color_t  channel_i,
  input  logic                     mask_i,
  input  color_track_pkg::com_t [color_track_pkg::NUM_TARGETS-1:0] com_i,
  input  logic [color_track_pkg::NUM_TARGETS-1:0]                  com_valid_i,
  input  color_track_pkg::display_e display_mode_i,
  input  logic                     crosshair_en_i,
  output logic                     out_valid_o,
  output color_track_pkg::rgb_t    pixel_o,
  output color_track_pkg::com_t [color_track_pkg::NUM_TARGETS-1:0] com_o
);

  color_track_pkg::rgb_t bg;
  logic                  on_cross;

  // keep the last published centroid of each target
  always_ff @(posedge clk_camera) begin
    for (int t = 0; t < color_track_pkg::NUM_TARGETS; t++) begin
      if (sys_rst_pixel) begin
        com_o[t] <= '0;
      end else if (com_valid_i[t]) begin
        com_o[t] <= com_i[t];
      end
    end
  end

  always_comb begin
    case (display_mode_i)
      color_track_pkg::channel_gray:   bg = '{channel_i, channel_i, channel_i};
      color_track_pkg::mask_white:     bg = mask_i ? '1 : '0;
      color_track_pkg::chroma_magenta: bg = mask_i ? color_track_pkg::MAGENTA : rgb_i;
      default:                         bg = rgb_i;
    endcase
  end

  // row or column of any latched centroid
  always_comb begin
    on_cross = 1'b0;
    for (int t = 0; t < color_track_pkg::NUM_TARGETS; t++) begin
      if (hcount_i == com_o[t].x || vcount_i == com_o[t].y) begin
        on_cross = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_camera) begin
    pixel_o <= (crosshair_en_i && on_cross) ? color_track_pkg::CROSSHAIR_COLOR : bg;
  end

endmodule

// File: color_track_top.sv
`timescale 1ns/10ps

module color_track_top (
  input  logic                      clk_camera,
  input  logic                      sys_rst_pixel,
  input  logic                      pixel_valid_i,
  input  color_track_pkg::pixel_in_t pixel_i,
  input  logic                      frame_end_i,
  input  color_track_pkg::target_cfg_t [color_track_pkg::NUM_TARGETS-1:0] target_cfg_i,
  input  color_track_pkg::display_e display_mode_i,
  input  logic                      crosshair_en_i,
  output logic                      out_valid_o,
  output color_track_pkg::rgb_t     pixel_o,
  output color_track_pkg::com_t [color_track_pkg::NUM_TARGETS-1:0] com_o,
  output logic [color_track_pkg::NUM_TARGETS-1:0]                  com_valid_o
);

  // conversion outputs, cycle 3
  color_track_pkg::rgb_t   rgb_c;
  color_track_pkg::ycrcb_t ycrcb_c;

  // everything below is aligned to the mask, cycle 4
  color_track_pkg::rgb_t                          rgb_d;
  color_track_pkg::color_t                        channel0;
  logic [color_track_pkg::NUM_TARGETS-1:0]        mask;
  logic                                           valid_d;
  logic                                           frame_end_d;
  color_track_pkg::hcount_t                       hcount_d;
  color_track_pkg::vcount_t                       vcount_d;
  color_track_pkg::com_t [color_track_pkg::NUM_TARGETS-1:0] com_calc;

  rgb_to_ycrcb u_color (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .pixel_i       (pixel_i.rgb),
    .rgb_o         (rgb_c),
    .ycrcb_o       (ycrcb_c)
  );

  // valid, frame end and coordinates ride alongside to the mask stage
  pixel_delay #(
    .WIDTH  (2 + $bits(color_track_pkg::hcount_t) + $bits(color_track_pkg::vcount_t)),
    .STAGES (color_track_pkg::MASK_LATENCY)
  ) u_side_delay (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .data_i        ({pixel_valid_i, frame_end_i, pixel_i.hcount, pixel_i.vcount}),
    .data_o        ({valid_d, frame_end_d, hcount_d, vcount_d})
  );

  // rgb waits out the threshold stage before the mux
  pixel_delay #(
    .WIDTH  ($bits(color_track_pkg::rgb_t)),
    .STAGES (color_track_pkg::OUT_LATENCY - 1 - color_track_pkg::COLOR_LATENCY)
  ) u_rgb_delay (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .data_i        (rgb_c),
    .data_o        (rgb_d)
  );

  // target 0 also feeds the display modes
  channel_mask u_mask0 (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .rgb_i         (rgb_c),
    .ycrcb_i       (ycrcb_c),
    .cfg_i         (target_cfg_i[0]),
    .channel_o     (channel0),
    .mask_o        (mask[0])
  );

  // target 1 only tracks
  channel_mask u_mask1 (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .rgb_i         (rgb_c),
    .ycrcb_i       (ycrcb_c),
    .cfg_i         (target_cfg_i[1]),
    .channel_o     (),
    .mask_o        (mask[1])
  );

  for (genvar t = 0; t < color_track_pkg::NUM_TARGETS; t++) begin : g_com
    center_of_mass u_com (
      .clk_camera    (clk_camera),
      .sys_rst_pixel (sys_rst_pixel),
      .valid_i       (valid_d),
      .mask_i        (mask[t]),
      .hcount_i      (hcount_d),
      .vcount_i      (vcount_d),
      .frame_end_i   (frame_end_d),
      .com_o         (com_calc[t]),
      .com_valid_o   (com_valid_o[t])
    );
  end

  overlay_mux u_mux (
    .clk_camera     (clk_camera),
    .sys_rst_pixel  (sys_rst_pixel),
    .valid_i        (valid_d),
    .hcount_i       (hcount_d),
    .vcount_i       (vcount_d),
    .rgb_i          (rgb_d),
    .channel_i      (channel0),
    .mask_i         (mask[0]),
    .com_i          (com_calc),
    .com_valid_i    (com_valid_o),
    .display_mode_i (display_mode_i),
    .crosshair_en_i (crosshair_en_i),
    .out_valid_o    (out_valid_o),
    .pixel_o        (pixel_o),
    .com_o          (com_o)
  );

endmodule

// File: tb_color_track.sv
`timescale 1ns/10ps

module tb_color_track;

  localparam int FRAME_W     = 16;
  localparam int FRAME_H     = 8;
  localparam int COM_TIMEOUT = 200;
  localparam int NT          = color_track_pkg::NUM_TARGETS;

  // red values just outside and exactly on the 0x40..0x80 bounds
  localparam logic [4:0] EDGE_RED [4] = '{5'd7, 5'd8, 5'd16, 5'd17};

  logic                                clk_camera = 1'b0;
  logic                                sys_rst_pixel;
  logic                                pixel_valid_i;
  color_track_pkg::pixel_in_t          pixel_i;
  logic                                frame_end_i;
  color_track_pkg::target_cfg_t [NT-1:0] target_cfg_i;
  color_track_pkg::display_e           display_mode_i;
  logic                                crosshair_en_i;
  logic                                out_valid_o;
  color_track_pkg::rgb_t               pixel_o;
  color_track_pkg::com_t [NT-1:0]      com_o;
  logic [NT-1:0]                       com_valid_o;

  // reference model state
  logic [31:0]           rng;
  color_track_pkg::rgb_t exp_q [$];
  color_track_pkg::com_t lat_com [NT];
  longint                x_sum [NT];
  longint                y_sum [NT];
  int                    hits [NT];

  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;
  string test_name;

  always #10 clk_camera = ~clk_camera;

  color_track_top dut (
    .clk_camera     (clk_camera),
    .sys_rst_pixel  (sys_rst_pixel),
    .pixel_valid_i  (pixel_valid_i),
    .pixel_i        (pixel_i),
    .frame_end_i    (frame_end_i),
    .target_cfg_i   (target_cfg_i),
    .display_mode_i (display_mode_i),
    .crosshair_en_i (crosshair_en_i),
    .out_valid_o    (out_valid_o),
    .pixel_o        (pixel_o),
    .com_o          (com_o),
    .com_valid_o    (com_valid_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 5:6:5 to 8:8:8 with zero low bits
  function automatic color_track_pkg::rgb_t expand(input color_track_pkg::rgb565_t p);
    color_track_pkg::rgb_t c;
    c.red   = {p[15:11], 3'b000};
    c.green = {p[10:5], 2'b00};
    c.blue  = {p[4:0], 3'b000};
    return c;
  endfunction

  // channel by code with luma and chroma from the weighted sums
  function automatic color_track_pkg::color_t pick(input int code,
                                                   input color_track_pkg::rgb_t c);
    int r;
    int g;
    int b;
    int v;
    r = int'(c.red);
    g = int'(c.green);
    b = int'(c.blue);
    case (code)
      0: v = g;
      1: v = r;
      2: v = b;
      4: v = (77 * r + 150 * g + 29 * b) >>> 8;
      5: v = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
      6: v = ((-43 * r - 85 * g + 128 * b) >>> 8) + 128;
      default: v = 0;
    endcase
    return color_track_pkg::color_t'(v);
  endfunction

  // inclusive at both ends
  function automatic logic in_range(input color_track_pkg::target_cfg_t cfg,
                                    input color_track_pkg::rgb_t c);
    color_track_pkg::color_t ch;
    ch = pick(int'(cfg.channel), c);
    return (ch >= cfg.lower) && (ch <= cfg.upper);
  endfunction

  function automatic color_track_pkg::target_cfg_t make_cfg(input int code,
                                                            input color_track_pkg::color_t lo,
                                                            input color_track_pkg::color_t hi);
    color_track_pkg::target_cfg_t cfg;
    cfg.channel = color_track_pkg::channel_e'(3'(code));
    cfg.lower   = lo;
    cfg.upper   = hi;
    return cfg;
  endfunction

  // display choice follows target 0 and a crosshair wins over everything
  function automatic color_track_pkg::rgb_t expected_pixel(input color_track_pkg::pixel_in_t p,
                                                           input color_track_pkg::target_cfg_t cfg,
                                                           input int mode,
                                                           input logic cross_en);
    color_track_pkg::rgb_t   c;
    color_track_pkg::color_t ch;
    logic                    m;
    c  = expand(p.rgb);
    ch = pick(int'(cfg.channel), c);
    m  = in_range(cfg, c);
    for (int t = 0; t < NT; t++) begin
      if (cross_en && (p.hcount == lat_com[t].x || p.vcount == lat_com[t].y)) begin
        return 24'hffffff;
      end
    end
    case (mode)
      1: return '{ch, ch, ch};
      2: return m ? 24'hffffff : 24'h000000;
      3: return m ? 24'hff00ff : c;
      default: return c;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v == exp_v) else begin
      $display("error %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  // output valid is the input strobe five edges later
  assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
                   out_valid_o == $past(pixel_valid_i, color_track_pkg::OUT_LATENCY))
    else begin
      $display("out_valid_o did not follow pixel_valid_i after five cycles in %s", test_name);
      errors++;
    end

  // each valid output takes the oldest pixel still in flight
  always @(negedge clk_camera) begin
    if (!sys_rst_pixel && out_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("output pixel appeared with no input pixel in flight in %s", test_name);
        errors++;
      end else begin
        check_value("pixel_o", 32'(exp_q.pop_front()), 32'(pixel_o));
      end
    end
  end

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // waits for every target that saw a masked pixel while empty frames wait out the window
  task automatic wait_centroids();
    logic [NT-1:0] want;
    logic [NT-1:0] seen;
    int            cycles;
    for (int t = 0; t < NT; t++) begin
      want[t] = (hits[t] != 0);
    end
    seen   = '0;
    cycles = 0;
    while (cycles < COM_TIMEOUT && (want == '0 || seen != want)) begin
      @(negedge clk_camera);
      cycles++;
      for (int t = 0; t < NT; t++) begin
        if (com_valid_o[t]) begin
          assert (want[t]) else begin
            $display("com_valid_o of target %0d pulsed after a frame with no masked pixel", t);
            errors++;
          end
          seen[t] = 1'b1;
        end
      end
    end
    for (int t = 0; t < NT; t++) begin
      if (want[t] && !seen[t]) begin
        $display("timed out waiting for com_valid_o of target %0d in %s", t, test_name);
        errors++;
      end else if (want[t]) begin
        lat_com[t].x = color_track_pkg::hcount_t'(x_sum[t] / hits[t]);
        lat_com[t].y = color_track_pkg::vcount_t'(y_sum[t] / hits[t]);
      end
    end
    // latch lands on the edge after the pulse
    repeat (2) @(negedge clk_camera);
    for (int t = 0; t < NT; t++) begin
      check_value($sformatf("com_o[%0d]", t), 32'(lat_com[t]), 32'(com_o[t]));
    end
  endtask

  // one 16 by 8 frame of random pixels and then the frame end pulse
  task automatic run_frame(input int mode, input logic cross_en,
                           input color_track_pkg::target_cfg_t cfg0,
                           input color_track_pkg::target_cfg_t cfg1);
    color_track_pkg::target_cfg_t cfg [NT];
    color_track_pkg::pixel_in_t   p;
    color_track_pkg::rgb_t        c;
    cfg[0] = cfg0;
    cfg[1] = cfg1;
    for (int t = 0; t < NT; t++) begin
      x_sum[t] = 0;
      y_sum[t] = 0;
      hits[t]  = 0;
    end
    for (int v = 0; v < FRAME_H; v++) begin
      for (int h = 0; h < FRAME_W; h++) begin
        rng      = xorshift(rng);
        p.hcount = color_track_pkg::hcount_t'(h);
        p.vcount = color_track_pkg::vcount_t'(v);
        p.rgb    = rng[15:0];
        if (v == 0 && h < 4) begin
          p.rgb[15:11] = EDGE_RED[h];
        end
        c = expand(p.rgb);
        @(posedge clk_camera);
        pixel_valid_i   <= 1'b1;
        pixel_i         <= p;
        target_cfg_i[0] <= cfg0;
        target_cfg_i[1] <= cfg1;
        display_mode_i  <= color_track_pkg::display_e'(2'(mode));
        crosshair_en_i  <= cross_en;
        for (int t = 0; t < NT; t++) begin
          if (in_range(cfg[t], c)) begin
            x_sum[t] += h;
            y_sum[t] += v;
            hits[t]++;
          end
        end
        exp_q.push_back(expected_pixel(p, cfg0, mode, cross_en));
      end
    end
    @(posedge clk_camera);
    pixel_valid_i <= 1'b0;
    frame_end_i   <= 1'b1;
    @(posedge clk_camera);
    frame_end_i <= 1'b0;
    wait_centroids();
  endtask

  initial begin
    rng          = 32'd13;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    for (int t = 0; t < NT; t++) begin
      lat_com[t] = '0;
    end
    sys_rst_pixel  = 1'b1;
    pixel_valid_i  = 1'b0;
    pixel_i        = '0;
    frame_end_i    = 1'b0;
    target_cfg_i   = '0;
    display_mode_i = color_track_pkg::camera;
    crosshair_en_i = 1'b0;
    repeat (3) @(posedge clk_camera);
    sys_rst_pixel <= 1'b0;

    begin_test("reset_idle");
    repeat (20) begin
      @(negedge clk_camera);
      check_value("out_valid_o", 32'(1'b0), 32'(out_valid_o));
      check_value("com_valid_o", 32'(2'b00), 32'(com_valid_o));
      for (int t = 0; t < NT; t++) begin
        check_value($sformatf("com_o[%0d]", t), 32'(0), 32'(com_o[t]));
      end
    end
    end_test();

    begin_test("camera_passthrough");
    run_frame(0, 1'b0, make_cfg(1, 8'h40, 8'h80), make_cfg(2, 8'h00, 8'h7f));
    end_test();

    // every code, including the two that select zero
    begin_test("channel_gray");
    for (int code = 0; code < 8; code++) begin
      run_frame(1, 1'b0, make_cfg(code, 8'h20, 8'hc0), make_cfg(6, 8'h80, 8'hff));
    end
    end_test();

    begin_test("mask_bounds");
    run_frame(2, 1'b0, make_cfg(1, 8'h40, 8'h80), make_cfg(4, 8'h40, 8'ha0));
    run_frame(3, 1'b0, make_cfg(1, 8'h40, 8'h80), make_cfg(5, 8'h70, 8'h90));
    end_test();

    // red never reaches 0xff and code 3 is always zero
    begin_test("empty_frame");
    run_frame(0, 1'b0, make_cfg(1, 8'hff, 8'hff), make_cfg(3, 8'h01, 8'hff));
    end_test();

    begin_test("crosshair");
    run_frame(0, 1'b1, make_cfg(5, 8'h70, 8'h90), make_cfg(0, 8'h80, 8'hff));
    run_frame(1, 1'b1, make_cfg(4, 8'h30, 8'hb0), make_cfg(2, 8'h00, 8'h60));
    end_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: files.f
color_track_pkg.sv
pixel_delay.sv
rgb_to_ycrcb.sv
channel_mask.sv
seq_divider.sv
center_of_mass.sv
overlay_mux.sv
color_track_top.sv
tb_color_track.sv

// File: run_sim.sh
#!/bin/sh
# build and run the color tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_color_track -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_color_track > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0
